// ==== src/pool_pkg.sv ====
package pool_pkg;

    ////////////////////////////////////////////////////////////
    // Feature map and window sizes
    ////////////////////////////////////////////////////////////
    localparam int IF_BW         = 8;
    localparam int POOL_K        = 2;
    localparam int POOL_IN_SIZE  = 8;
    localparam int STRIDE        = 2;
    localparam int WIN_PER_FRAME = (POOL_IN_SIZE / STRIDE) * (POOL_IN_SIZE / STRIDE);

    typedef logic [IF_BW-1:0]                 pixel_t;
    // Pixel i sits at [i*IF_BW +: IF_BW], i = row*2 + col, row 0 is the older row
    typedef logic [POOL_K*POOL_K*IF_BW-1:0]   window_t;
    typedef logic [15:0]                      result_t;
    typedef logic [15:0]                      count_t;
    typedef logic [$clog2(POOL_IN_SIZE)-1:0]  coord_t;

    ////////////////////////////////////////////////////////////
    // Pool modes and APB register map
    ////////////////////////////////////////////////////////////
    localparam logic [1:0] MODE_MAX  = 2'd0;
    localparam logic [1:0] MODE_AVG  = 2'd1;
    localparam logic [1:0] MODE_BOTH = 2'd2;

    localparam logic [3:0] ADDR_CTRL  = 4'h0;
    localparam logic [3:0] ADDR_COUNT = 4'h4;

    typedef enum logic [1:0] {
        FILL_ROW,
        PAIR_ROW,
        FRAME_DONE
    } lb_state_t;

endpackage

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_en,
    input  logic              i_in_valid,
    input  pool_pkg::pixel_t  i_in_pixel,
    output logic              o_window_valid,
    output pool_pkg::window_t o_window,
    output logic              o_window_last
);
    import pool_pkg::*;

    lb_state_t state;
    coord_t    x_cnt;
    coord_t    y_cnt;
    pixel_t    row_mem [0:POOL_IN_SIZE-1];
    pixel_t    prev_pixel;
    logic      accept;
    logic      x_end;
    logic      y_end;
    logic      win_done;

    assign accept   = i_en && i_in_valid;
    assign x_end    = (x_cnt == coord_t'(POOL_IN_SIZE - 1));
    assign y_end    = (y_cnt == coord_t'(POOL_IN_SIZE - 1));
    // Odd column of an odd row closes a stride-2 window
    assign win_done = accept && (state == PAIR_ROW) && ((x_cnt % STRIDE) == (STRIDE - 1));

    ////////////////////////////////////////////////////////////
    // Raster position
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (accept) begin
            if (x_end) begin
                x_cnt <= '0;
                y_cnt <= y_end ? '0 : y_cnt + 3'd1;
            end else begin
                x_cnt <= x_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= FILL_ROW;
        end else begin
            case (state)
                FILL_ROW: begin
                    if (accept && x_end) state <= PAIR_ROW;
                end
                PAIR_ROW: begin
                    if (accept && x_end) state <= y_end ? FRAME_DONE : FILL_ROW;
                end
                // Single cycle marker between frames
                FRAME_DONE: state <= FILL_ROW;
                default:    state <= FILL_ROW;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Row store and window capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        // Even rows land in the store, also during FRAME_DONE
        if (accept && (state != PAIR_ROW)) row_mem[x_cnt] <= i_in_pixel;
        if (accept && (state == PAIR_ROW)) prev_pixel <= i_in_pixel;
        if (win_done) begin
            o_window <= {i_in_pixel, prev_pixel, row_mem[x_cnt], row_mem[x_cnt - 3'd1]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_window_valid <= 1'b0;
            o_window_last  <= 1'b0;
        end else begin
            o_window_valid <= win_done;
            o_window_last  <= win_done && x_end && y_end;
        end
    end

endmodule

// ==== src/max_pool.sv ====
`timescale 1ns/1ps

module max_pool (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_window_valid,
    input  pool_pkg::window_t i_window,
    output logic              o_max_valid,
    output pool_pkg::pixel_t  o_max
);
    import pool_pkg::*;

    pixel_t max_top;
    pixel_t max_bot;
    pixel_t max_all;

    // Two-level compare tree, unsigned pixels
    assign max_top = (i_window[0*IF_BW +: IF_BW] > i_window[1*IF_BW +: IF_BW]) ?
                     i_window[0*IF_BW +: IF_BW] : i_window[1*IF_BW +: IF_BW];
    assign max_bot = (i_window[2*IF_BW +: IF_BW] > i_window[3*IF_BW +: IF_BW]) ?
                     i_window[2*IF_BW +: IF_BW] : i_window[3*IF_BW +: IF_BW];
    assign max_all = (max_top > max_bot) ? max_top : max_bot;

    always_ff @(posedge clk) begin
        if (i_window_valid) o_max <= max_all;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_max_valid <= 1'b0;
        end else begin
            o_max_valid <= i_window_valid;
        end
    end

endmodule

// ==== src/avg_pool.sv ====
`timescale 1ns/1ps

module avg_pool (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_window_valid,
    input  pool_pkg::window_t i_window,
    output logic              o_avg_valid,
    output pool_pkg::pixel_t  o_avg
);
    import pool_pkg::*;

    logic [IF_BW+1:0] sum;

    // Four 8-bit terms fit in 10 bits
    assign sum = {2'b00, i_window[0*IF_BW +: IF_BW]}
               + {2'b00, i_window[1*IF_BW +: IF_BW]}
               + {2'b00, i_window[2*IF_BW +: IF_BW]}
               + {2'b00, i_window[3*IF_BW +: IF_BW]};

    // Shift by two gives the floor of sum / 4
    always_ff @(posedge clk) begin
        if (i_window_valid) o_avg <= sum[IF_BW+1:2];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_avg_valid <= 1'b0;
        end else begin
            o_avg_valid <= i_window_valid;
        end
    end

endmodule

// ==== src/pool_merge.sv ====
`timescale 1ns/1ps

module pool_merge (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [1:0]        i_mode,
    input  logic              i_max_valid,
    input  pool_pkg::pixel_t  i_max,
    input  logic              i_avg_valid,
    input  pool_pkg::pixel_t  i_avg,
    input  logic              i_window_last,
    input  logic              i_count_clr,
    output logic              o_out_valid,
    output pool_pkg::result_t o_out_result,
    output logic              o_out_last,
    output pool_pkg::count_t  o_count
);
    import pool_pkg::*;

    logic    both_valid;
    logic    last_d;
    result_t result_next;

    assign both_valid = i_max_valid && i_avg_valid;

    always_comb begin
        case (i_mode)
            MODE_MAX: result_next = {8'h00, i_max};
            MODE_AVG: result_next = {8'h00, i_avg};
            // MODE_BOTH and the spare code 3
            default:  result_next = {i_max, i_avg};
        endcase
    end

    always_ff @(posedge clk) begin
        if (both_valid) o_out_result <= result_next;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_d      <= 1'b0;
            o_out_valid <= 1'b0;
            o_out_last  <= 1'b0;
        end else begin
            last_d      <= i_window_last;   // line buffer to pool unit delay
            o_out_valid <= both_valid;
            o_out_last  <= both_valid && last_d;
        end
    end

    // Result counter, clear has priority
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_count <= '0;
        end else if (i_count_clr) begin
            o_count <= '0;
        end else if (o_out_valid) begin
            o_count <= o_count + 16'd1;
        end
    end

endmodule

// ==== src/pool_apb_regs.sv ====
`timescale 1ns/1ps

module pool_apb_regs (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             i_psel,
    input  logic             i_penable,
    input  logic             i_pwrite,
    input  logic [3:0]       i_paddr,
    input  logic [31:0]      i_pwdata,
    output logic [31:0]      o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    output logic             o_en,
    output logic [1:0]       o_mode,
    output logic             o_count_clr,
    input  pool_pkg::count_t i_count
);
    import pool_pkg::*;

    logic access;
    logic hit_ctrl;
    logic hit_count;
    logic wr_ctrl;

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////
    assign access    = i_psel && i_penable;
    assign hit_ctrl  = (i_paddr == ADDR_CTRL);
    assign hit_count = (i_paddr == ADDR_COUNT);
    assign wr_ctrl   = access && i_pwrite && hit_ctrl;

    // No wait states
    assign o_pready  = 1'b1;
    // Unknown address, or a write to the read-only count
    assign o_pslverr = access && (!(hit_ctrl || hit_count) || (i_pwrite && hit_count));

    always_comb begin
        o_prdata = 32'h0;
        if (access && !i_pwrite) begin
            if (hit_ctrl)  o_prdata = {28'h0, 1'b0, o_mode, o_en};
            if (hit_count) o_prdata = {16'h0, i_count};
        end
    end

    ////////////////////////////////////////////////////////////
    // CTRL fields
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_en        <= 1'b0;
            o_mode      <= MODE_MAX;
            o_count_clr <= 1'b0;
        end else begin
            o_count_clr <= wr_ctrl && i_pwdata[3];   // self-clearing
            if (wr_ctrl) begin
                o_en   <= i_pwdata[0];
                o_mode <= i_pwdata[2:1];
            end
        end
    end

endmodule

// ==== src/pool_core.sv ====
`timescale 1ns/1ps

module pool_core (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  pool_pkg::pixel_t  i_in_pixel,
    output logic              o_out_valid,
    output pool_pkg::result_t o_out_result,
    output logic              o_out_last,
    input  logic              i_psel,
    input  logic              i_penable,
    input  logic              i_pwrite,
    input  logic [3:0]        i_paddr,
    input  logic [31:0]       i_pwdata,
    output logic [31:0]       o_prdata,
    output logic              o_pready,
    output logic              o_pslverr
);
    import pool_pkg::*;

    logic       en;
    logic [1:0] mode;
    logic       count_clr;
    count_t     count;
    logic       window_valid;
    window_t    window;
    logic       window_last;
    logic       max_valid;
    pixel_t     max_val;
    logic       avg_valid;
    pixel_t     avg_val;

    ////////////////////////////////////////////////////////////
    // Configuration
    ////////////////////////////////////////////////////////////
    pool_apb_regs u_regs (
        .clk(clk), .reset_n(reset_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
        .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_en(en), .o_mode(mode), .o_count_clr(count_clr), .i_count(count)
    );

    ////////////////////////////////////////////////////////////
    // Pixel pipeline
    ////////////////////////////////////////////////////////////
    line_buffer u_line_buffer (
        .clk(clk), .reset_n(reset_n), .i_en(en),
        .i_in_valid(i_in_valid), .i_in_pixel(i_in_pixel),
        .o_window_valid(window_valid), .o_window(window), .o_window_last(window_last)
    );

    max_pool u_max_pool (
        .clk(clk), .reset_n(reset_n),
        .i_window_valid(window_valid), .i_window(window),
        .o_max_valid(max_valid), .o_max(max_val)
    );

    avg_pool u_avg_pool (
        .clk(clk), .reset_n(reset_n),
        .i_window_valid(window_valid), .i_window(window),
        .o_avg_valid(avg_valid), .o_avg(avg_val)
    );

    pool_merge u_merge (
        .clk(clk), .reset_n(reset_n), .i_mode(mode),
        .i_max_valid(max_valid), .i_max(max_val),
        .i_avg_valid(avg_valid), .i_avg(avg_val),
        .i_window_last(window_last), .i_count_clr(count_clr),
        .o_out_valid(o_out_valid), .o_out_result(o_out_result),
        .o_out_last(o_out_last), .o_count(count)
    );

endmodule

// ==== verif/pool_core_checker.sv ====
`timescale 1ns/1ps

module pool_core_checker (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  pool_pkg::pixel_t  i_in_pixel,
    input  logic              i_psel,
    input  logic              i_penable,
    input  logic              i_pwrite,
    input  logic [3:0]        i_paddr,
    input  logic [31:0]       i_pwdata,
    input  logic              i_out_valid,
    input  pool_pkg::result_t i_out_result,
    input  logic              i_out_last,
    input  logic              i_drain_check,
    output int                o_errors
);
    import pool_pkg::*;

    pixel_t  pix_mem [0:63];
    result_t exp_result [$];
    logic    exp_last [$];
    int      exp_cycle [$];
    int      cycle;
    int      x;
    int      y;
    logic    en;
    logic [1:0] mode;

    function automatic result_t expected_word(input pixel_t a, input pixel_t b,
                                              input pixel_t c, input pixel_t d,
                                              input logic [1:0] m);
        pixel_t    mx;
        int        sum;
        logic [7:0] av;
        mx = a;
        if (b > mx) mx = b;
        if (c > mx) mx = c;
        if (d > mx) mx = d;
        sum = int'(a) + int'(b) + int'(c) + int'(d);
        av = 8'(sum / 4);
        if (m == MODE_MAX) return {8'h00, mx};
        if (m == MODE_AVG) return {8'h00, av};
        return {mx, av};
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cycle = 0;
            x = 0;
            y = 0;
            en = 1'b0;
            mode = MODE_MAX;
            o_errors = 0;
            exp_result.delete();
            exp_last.delete();
            exp_cycle.delete();
        end else begin
            cycle++;
            ////////////////////////////////////////////////////////////
            // Output side
            ////////////////////////////////////////////////////////////
            if (i_out_valid) begin
                if (exp_result.size() == 0) begin
                    $display("Extra result seen on o_out_valid at cycle %0d", cycle);
                    o_errors++;
                end else begin
                    if (i_out_result !== exp_result[0]) begin
                        $display("[ERROR] o_out_result expected 0x%h got 0x%h",
                                 exp_result[0], i_out_result);
                        o_errors++;
                    end
                    if (i_out_last !== exp_last[0]) begin
                        $display("[ERROR] o_out_last expected 0x%h got 0x%h",
                                 exp_last[0], i_out_last);
                        o_errors++;
                    end
                    if (cycle != exp_cycle[0]) begin
                        $display("Result came at cycle %0d instead of cycle %0d",
                                 cycle, exp_cycle[0]);
                        o_errors++;
                    end
                    void'(exp_result.pop_front());
                    void'(exp_last.pop_front());
                    void'(exp_cycle.pop_front());
                end
            end
            // Input side, uses the enable from before this edge
            if (i_in_valid && en) begin
                pix_mem[y*8+x] = i_in_pixel;
                if ((y % 2 == 1) && (x % 2 == 1)) begin
                    exp_result.push_back(expected_word(pix_mem[(y-1)*8+x-1],
                        pix_mem[(y-1)*8+x], pix_mem[y*8+x-1], i_in_pixel, mode));
                    exp_last.push_back((x == 7) && (y == 7));
                    exp_cycle.push_back(cycle + 3);
                end
                x++;
                if (x == 8) begin
                    x = 0;
                    y = (y == 7) ? 0 : y + 1;
                end
            end
            // Track CTRL writes on the bus
            if (i_psel && i_penable && i_pwrite && (i_paddr == ADDR_CTRL)) begin
                en = i_pwdata[0];
                mode = i_pwdata[2:1];
            end
            if (i_drain_check && (exp_result.size() != 0)) begin
                $display("Missing results, %0d windows never came out", exp_result.size());
                o_errors++;
            end
        end
    end

endmodule

// ==== verif/pool_core_assert.sv ====
`timescale 1ns/1ps

module pool_core_assert (
    input logic             clk,
    input logic             reset_n,
    input logic             i_window_valid,
    input logic             i_window_last,
    input logic             i_max_valid,
    input pool_pkg::pixel_t i_max,
    input pool_pkg::pixel_t i_avg,
    input logic             i_out_last
);

    int fail_count = 0;

    // A window maximum is never below its floor average
    max_above_avg: assert property (@(posedge clk) disable iff (!reset_n)
        i_max_valid |-> (i_max >= i_avg))
        else begin
            $error("max below avg for the same window");
            fail_count++;
        end

    // Windows close on odd columns only, so never on two cycles in a row
    window_spacing: assert property (@(posedge clk) disable iff (!reset_n)
        i_window_valid |-> !$past(i_window_valid))
        else begin
            $error("two windows on consecutive cycles");
            fail_count++;
        end

    // Last flag keeps step with the pool and merge stages
    last_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        i_out_last == $past(i_window_last, 2))
        else begin
            $error("o_out_last out of step with the window last flag");
            fail_count++;
        end

endmodule

// Attached at the top level, where every pipeline stage is visible
bind pool_core pool_core_assert assert_i (
    .clk(clk), .reset_n(reset_n),
    .i_window_valid(window_valid), .i_window_last(window_last),
    .i_max_valid(max_valid), .i_max(max_val), .i_avg(avg_val),
    .i_out_last(o_out_last)
);

// ==== verif/pool_core_tb.sv ====
`timescale 1ns/1ps

module pool_core_tb;
    import pool_pkg::*;

    localparam int NUM_FRAMES = 7;
    // One row per frame: mode, source (0 ramp, 1 LFSR), idle cycles between pixels
    localparam logic [1:0] TBL_MODE [NUM_FRAMES] =
        '{MODE_MAX, MODE_MAX, MODE_AVG, MODE_BOTH, MODE_BOTH, MODE_AVG, MODE_BOTH};
    localparam logic TBL_SRC [NUM_FRAMES] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
    localparam int   TBL_GAP [NUM_FRAMES] = '{0, 0, 1, 0, 0, 1, 0};

    logic        clk = 1'b0;
    logic        reset_n;
    logic        i_in_valid;
    pixel_t      i_in_pixel;
    logic        o_out_valid;
    result_t     o_out_result;
    logic        o_out_last;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [3:0]  i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        drain_check;
    int          chk_errors;
    int          tb_errors;
    int          exp_count;
    logic [16:0] lfsr_state;

    always #4 clk = ~clk;

    pool_core dut_i (.*);

    pool_core_checker chk_i (
        .clk(clk), .reset_n(reset_n), .i_in_valid(i_in_valid), .i_in_pixel(i_in_pixel),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite), .i_paddr(i_paddr),
        .i_pwdata(i_pwdata), .i_out_valid(o_out_valid), .i_out_result(o_out_result),
        .i_out_last(o_out_last), .i_drain_check(drain_check), .o_errors(chk_errors)
    );

    initial begin
        #((NUM_FRAMES * 200 + 100) * 8);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic random_pixel(output pixel_t p);
        p = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            p = {p[6:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB and pixel drivers
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1 i_psel = 1'b1;
        i_penable = 1'b0;
        i_pwrite = wr;
        i_paddr = addr;
        i_pwdata = wdata;
        @(posedge clk);
        #1 i_penable = 1'b1;
        // Response is settled by mid access cycle
        @(negedge clk);
        rdata = o_prdata;
        err = o_pslverr;
        if (o_pready !== 1'b1) begin
            $display("[ERROR] o_pready expected 0x1 got 0x%h", o_pready);
            tb_errors++;
        end
        @(posedge clk);
        #1 i_psel = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic check_count(input int expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, ADDR_COUNT, 32'h0, rdata, err);
        if (err) begin
            $display("Read of COUNT gave a slave error");
            tb_errors++;
        end
        if (rdata !== 32'(expected)) begin
            $display("[ERROR] o_prdata expected 0x%h got 0x%h", 32'(expected), rdata);
            tb_errors++;
        end
    endtask

    task automatic stream_pixels(input int n, input logic src, input int gap, input int base);
        pixel_t p;
        for (int i = 0; i < n; i++) begin
            if (src) random_pixel(p);
            else p = 8'(base + i * 4);
            @(posedge clk);
            #1 i_in_valid = 1'b1;
            i_in_pixel = p;
            repeat (gap) begin
                @(posedge clk);
                #1 i_in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1 i_in_valid = 1'b0;
    endtask

    task automatic wait_for_last();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_out_last && n < 200);
        if (!o_out_last) begin
            $display("Timed out waiting for o_out_last");
            tb_errors++;
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        reset_n = 1'b0;
        i_in_valid = 1'b0;
        i_in_pixel = '0;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;
        drain_check = 1'b0;
        tb_errors = 0;
        exp_count = 0;
        lfsr_state = 17'd87265;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            apb_access(1'b1, ADDR_CTRL, {29'h0, TBL_MODE[f], 1'b1}, rdata, err);
            stream_pixels(64, TBL_SRC[f], TBL_GAP[f], f * 16);
            wait_for_last();
            exp_count += WIN_PER_FRAME;
            check_count(exp_count);
            if (f == 4) begin
                // Count clear, bus errors, then a disabled stream
                apb_access(1'b1, ADDR_CTRL, 32'h8, rdata, err);
                exp_count = 0;
                check_count(0);
                apb_access(1'b0, 4'h8, 32'h0, rdata, err);
                if (!err) begin
                    $display("Read of address 0x8 gave no slave error");
                    tb_errors++;
                end
                apb_access(1'b1, ADDR_COUNT, 32'h1, rdata, err);
                if (!err) begin
                    $display("Write to COUNT gave no slave error");
                    tb_errors++;
                end
                stream_pixels(20, 1'b0, 0, 3);
                repeat (10) @(posedge clk);
                check_count(0);
            end
        end

        @(posedge clk);
        #1 drain_check = 1'b1;
        @(posedge clk);
        #1 drain_check = 1'b0;
        repeat (2) @(posedge clk);
        $display("Errors: checker %0d, testbench %0d, assertions %0d",
                 chk_errors, tb_errors, dut_i.assert_i.fail_count);
        if (chk_errors == 0 && tb_errors == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== pool_core.f ====
src/pool_pkg.sv
src/line_buffer.sv
src/max_pool.sv
src/avg_pool.sv
src/pool_merge.sv
src/pool_apb_regs.sv
src/pool_core.sv
verif/pool_core_checker.sv
verif/pool_core_assert.sv
verif/pool_core_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vpool_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wall -f pool_core.f \
		--top-module pool_core_tb -Mdir obj_dir

run: build
	./$(BIN) | tee /dev/stderr | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f pool_core.f \
		--top-module pool_core_tb
	verilator --lint-only -Wall src/pool_pkg.sv src/line_buffer.sv src/max_pool.sv \
		src/avg_pool.sv src/pool_merge.sv src/pool_apb_regs.sv src/pool_core.sv \
		--top-module pool_core

clean:
	rm -rf obj_dir
